// File: design/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// bus word is {rs, rw, data[7:0]}
	localparam int lcd_bus_w = 10;

	// {lines, font, display on, cursor, blink, inc/dec, shift}
	localparam int cfg_w = 7;

	// top bit selects the line, low 4 bits the column
	localparam int pos_w = 5;

	localparam logic [7:0] cmd_set_ddram = 8'h80;	// or'ed with the ddram address
	localparam logic [7:0] line2_offset = 8'h40;	// first ddram address of line 2

	// timing points, all in microseconds
	localparam int t_powerup_us = 500;			// wait before the first command
	localparam int t_fn_wait_us = 50;			// after function set and display control
	localparam int t_clear_wait_us = 200;		// clear takes longer
	localparam int t_entry_wait_us = 100;		// after entry mode set
	localparam int t_write_us = 50;				// full length of one host write
	localparam int t_e_high_start_us = 1;		// e rises here in a write
	localparam int t_e_high_end_us = 14;		// and falls here

endpackage

`default_nettype wire

// File: design/char_queue.sv
`default_nettype none
`timescale 1ns/10ps

module char_queue #(
	parameter int queue_depth = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [lcd_pkg::pos_w-1:0] in_pos,
	input  logic [7:0]               in_char,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [lcd_pkg::pos_w-1:0] out_pos,
	output logic [7:0]               out_char
);
	import lcd_pkg::*;

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	logic [pos_w-1:0] pos_mem [queue_depth];
	logic [7:0]       char_mem [queue_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             push;
	logic             pop;

	assign in_ready  = (count != cnt_w'(queue_depth));	// full blocks the host
	assign out_valid = (count != '0);
	assign out_pos   = pos_mem[rd_ptr];
	assign out_char  = char_mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			pos_mem[wr_ptr]  <= in_pos;
			char_mem[wr_ptr] <= in_char;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				// explicit wrap, depth need not be a power of two
				wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;			// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/lcd_writer.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_writer (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [lcd_pkg::cfg_w-1:0]     cfg,
	input  logic                         init_done,
	input  logic                         req_valid,
	output logic                         req_ready,
	input  logic [lcd_pkg::pos_w-1:0]     req_pos,
	input  logic [7:0]                   req_char,
	output logic                         bus_enable,
	output logic [lcd_pkg::lcd_bus_w-1:0] bus_word,
	input  logic                         busy
);
	import lcd_pkg::*;

	localparam int id_bit = 1;	// increment/decrement field of cfg

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data
	} wr_state_t;

	wr_state_t state;

	logic [6:0] cursor;			// where the lcd will put the next byte
	logic [6:0] req_addr;
	logic [6:0] tgt_addr;
	logic [7:0] char_q;
	logic [6:0] next_cursor;
	logic [3:0] req_col;
	logic       accept;
	logic       issue;

	assign req_col = req_pos[pos_w-2:0];

	// ddram address of the requested screen position
	always_comb begin
		if (req_pos[pos_w-1]) begin
			req_addr = line2_offset[6:0] + 7'(req_col);
		end else begin
			req_addr = 7'(req_col);
		end
	end

	assign req_ready = (state == st_idle);
	assign accept    = req_valid && req_ready;

	// one word per controller idle window
	assign issue      = (state != st_idle) && init_done && !busy;
	assign bus_enable = issue;

	always_comb begin
		case (state)
			st_addr: bus_word = {1'b0, 1'b0, cmd_set_ddram | {1'b0, tgt_addr}};
			st_data: bus_word = {1'b1, 1'b0, char_q};		// rs high for data
			default: bus_word = '0;
		endcase
	end

	// lcd moves its cursor by itself after each data byte
	assign next_cursor = cfg[id_bit] ? cursor + 7'd1 : cursor - 7'd1;

	always_ff @(posedge clk) begin
		if (accept) begin
			tgt_addr <= req_addr;
			char_q   <= req_char;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= st_idle;
			cursor <= '0;			// clear command homes the cursor
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						// skip the address command when already in place
						state <= (req_addr == cursor) ? st_data : st_addr;
					end
				end
				st_addr: begin
					if (issue) begin
						cursor <= tgt_addr;
						state  <= st_data;
					end
				end
				st_data: begin
					if (issue) begin
						cursor <= next_cursor;
						state  <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/lcd_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_ctrl #(
	parameter int clk_freq = 40			// cycles per microsecond
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [lcd_pkg::cfg_w-1:0]     cfg,
	input  logic                         lcd_enable,
	input  logic [lcd_pkg::lcd_bus_w-1:0] lcd_bus,
	output logic                         busy,
	output logic                         init_done,
	output logic                         e,
	output logic                         rs,
	output logic                         rw,
	output logic [7:0]                   lcd_data
);
	import lcd_pkg::*;

	localparam int t_init_pulse_us = 10;	// e high time of each init command

	// init sequence boundaries in cycles from the start of the sequence
	localparam int fn_end       = t_init_pulse_us * clk_freq;
	localparam int fn_wait_end  = fn_end + t_fn_wait_us * clk_freq;
	localparam int ctl_end      = fn_wait_end + t_init_pulse_us * clk_freq;
	localparam int ctl_wait_end = ctl_end + t_fn_wait_us * clk_freq;
	localparam int clr_end      = ctl_wait_end + t_init_pulse_us * clk_freq;
	localparam int clr_wait_end = clr_end + t_clear_wait_us * clk_freq;
	localparam int ent_end      = clr_wait_end + t_init_pulse_us * clk_freq;
	localparam int init_end     = ent_end + t_entry_wait_us * clk_freq;

	localparam int pw_end   = t_powerup_us * clk_freq;
	localparam int e_start  = t_e_high_start_us * clk_freq;
	localparam int e_end    = t_e_high_end_us * clk_freq;
	localparam int wr_end   = t_write_us * clk_freq + 1;
	localparam int cnt_w    = $clog2(pw_end + 1);	// power-up wait is the longest

	typedef enum logic [1:0] {
		st_power,
		st_init,
		st_idle,
		st_write
	} ctrl_state_t;

	ctrl_state_t state;

	logic [cnt_w-1:0] cnt;
	logic             init_e;
	logic [7:0]       init_byte;

	// command on the bus for the current point of the init sequence
	always_comb begin
		init_e    = 1'b0;
		init_byte = 8'h00;
		if (cnt < fn_end) begin
			init_e    = 1'b1;
			init_byte = {4'b0011, cfg[6], cfg[5], 2'b00};		// function set
		end else if (cnt >= fn_wait_end && cnt < ctl_end) begin
			init_e    = 1'b1;
			init_byte = {5'b00001, cfg[4], cfg[3], cfg[2]};	// display control
		end else if (cnt >= ctl_wait_end && cnt < clr_end) begin
			init_e    = 1'b1;
			init_byte = 8'b0000_0001;							// clear
		end else if (cnt >= clr_wait_end && cnt < ent_end) begin
			init_e    = 1'b1;
			init_byte = {6'b000001, cfg[1], cfg[0]};			// entry mode
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_power;
			cnt       <= '0;
			busy      <= 1'b1;			// no writes until init is over
			init_done <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= 8'h00;
		end else begin
			case (state)
				st_power: begin
					if (cnt < pw_end) begin
						cnt <= cnt + 1'b1;
					end else begin
						cnt   <= '0;
						state <= st_init;
					end
				end
				st_init: begin
					if (cnt < init_end) begin
						cnt      <= cnt + 1'b1;
						e        <= init_e;
						lcd_data <= init_byte;		// zero between commands
					end else begin
						cnt       <= '0;
						busy      <= 1'b0;
						init_done <= 1'b1;
						e         <= 1'b0;
						lcd_data  <= 8'h00;
						state     <= st_idle;
					end
				end
				st_idle: begin
					if (lcd_enable) begin
						rs       <= lcd_bus[9];
						rw       <= lcd_bus[8];
						lcd_data <= lcd_bus[7:0];
						busy     <= 1'b1;
						cnt      <= cnt_w'(1);	// counts cycles since acceptance
						state    <= st_write;
					end
				end
				st_write: begin
					if (cnt < wr_end) begin
						// setup, then the enable pulse, then hold
						e   <= (cnt >= e_start) && (cnt < e_end);
						cnt <= cnt + 1'b1;
					end else begin
						cnt      <= '0;
						busy     <= 1'b0;
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
						state    <= st_idle;
					end
				end
				default: state <= st_power;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/lcd_top.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_top #(
	parameter int clk_freq    = 40,
	parameter int queue_depth = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [lcd_pkg::cfg_w-1:0] cfg,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  logic [lcd_pkg::pos_w-1:0] req_pos,
	input  logic [7:0]               req_char,
	output logic                     init_done,
	output logic                     lcd_e,
	output logic                     lcd_rs,
	output logic                     lcd_rw,
	output logic [7:0]               lcd_data
);
	import lcd_pkg::*;

	logic                 q_valid;		// queue head to writer
	logic                 q_ready;
	logic [pos_w-1:0]     q_pos;
	logic [7:0]           q_char;
	logic                 bus_enable;	// writer to controller
	logic [lcd_bus_w-1:0] bus_word;
	logic                 busy;

	char_queue #(
		.queue_depth(queue_depth)
	) u_queue (
		.clk      (clk),
		.rst      (rst),
		.in_valid (req_valid),
		.in_ready (req_ready),
		.in_pos   (req_pos),
		.in_char  (req_char),
		.out_valid(q_valid),
		.out_ready(q_ready),
		.out_pos  (q_pos),
		.out_char (q_char)
	);

	lcd_writer u_writer (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.init_done (init_done),
		.req_valid (q_valid),
		.req_ready (q_ready),
		.req_pos   (q_pos),
		.req_char  (q_char),
		.bus_enable(bus_enable),
		.bus_word  (bus_word),
		.busy      (busy)
	);

	lcd_ctrl #(
		.clk_freq(clk_freq)
	) u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.lcd_enable(bus_enable),
		.lcd_bus   (bus_word),
		.busy      (busy),
		.init_done (init_done),
		.e         (lcd_e),
		.rs        (lcd_rs),
		.rw        (lcd_rw),
		.lcd_data  (lcd_data)
	);

endmodule

`default_nettype wire

// File: tests/lcd_bus_model.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_bus_model #(
	parameter int clk_freq = 40
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         e,
	input  logic                         rs,
	input  logic                         rw,
	input  logic [7:0]                   data,
	input  logic                         init_done,
	output logic                         cap_valid,
	output logic [lcd_pkg::lcd_bus_w-1:0] cap_word,
	output int                           bus_errors
);
	import lcd_pkg::*;

	localparam int init_pulse  = 10 * clk_freq;	// e high time of an init command
	localparam int write_pulse = (t_e_high_end_us - t_e_high_start_us) * clk_freq;

	int                   high_cnt;
	int                   expect_len;
	logic [lcd_bus_w-1:0] held;

	initial begin
		bus_errors = 0;
		high_cnt   = 0;
		cap_valid  = 1'b0;
		cap_word   = '0;
	end

	// bus sampled at the clock, a falling e is seen one edge after it drops
	always @(posedge clk) begin
		cap_valid <= 1'b0;
		if (rst) begin
			high_cnt <= 0;
		end else if (e) begin
			if (high_cnt == 0) begin
				held <= {rs, rw, data};			// lcd latches on the falling edge
			end else if ({rs, rw, data} != held) begin
				$display("bus changed from %h to %h while e was high", held, {rs, rw, data});
				bus_errors <= bus_errors + 1;
			end
			high_cnt <= high_cnt + 1;
		end else if (high_cnt != 0) begin
			expect_len = init_done ? write_pulse : init_pulse;
			if (high_cnt != expect_len) begin
				$display("e was high for %0d cycles where %0d were expected",
					high_cnt, expect_len);
				bus_errors <= bus_errors + 1;
			end
			cap_valid <= 1'b1;
			cap_word  <= held;
			high_cnt  <= 0;
		end
	end

endmodule

`default_nettype wire

// File: tests/lcd_tb.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_tb;
	import lcd_pkg::*;

	localparam int clk_freq     = 1;
	localparam int queue_depth  = 4;
	localparam int id_bit       = 1;			// increment/decrement field of cfg
	localparam int init_latency = (t_powerup_us + 440) * clk_freq + 2;
	localparam int init_limit   = 2 * init_latency;
	localparam int ready_limit  = 2000;
	localparam int drain_limit  = 5000;

	logic                 clk;
	logic                 rst;
	logic [cfg_w-1:0]     cfg;
	logic                 req_valid;
	logic                 req_ready;
	logic [pos_w-1:0]     req_pos;
	logic [7:0]           req_char;
	logic                 init_done;
	logic                 lcd_e;
	logic                 lcd_rs;
	logic                 lcd_rw;
	logic [7:0]           lcd_data;
	logic                 cap_valid;
	logic [lcd_bus_w-1:0] cap_word;
	int                   bus_errors;

	logic [lcd_bus_w-1:0] exp_q [$];
	logic [lcd_bus_w-1:0] exp_word;
	logic [6:0]           cursor_ref;			// where the lcd cursor should be
	logic [31:0]          rand_state = 32'heb8321bd;
	int                   value_errors;
	int                   other_errors;
	bit                   timed_out;

	lcd_top #(
		.clk_freq   (clk_freq),
		.queue_depth(queue_depth)
	) dut0 (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_pos  (req_pos),
		.req_char (req_char),
		.init_done(init_done),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_data (lcd_data)
	);

	lcd_bus_model #(
		.clk_freq(clk_freq)
	) bus0 (
		.clk       (clk),
		.rst       (rst),
		.e         (lcd_e),
		.rs        (lcd_rs),
		.rw        (lcd_rw),
		.data      (lcd_data),
		.init_done (init_done),
		.cap_valid (cap_valid),
		.cap_word  (cap_word),
		.bus_errors(bus_errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// {rs, rw, data} of the four power-up commands
	function automatic logic [lcd_bus_w-1:0] init_word(input int idx, input logic [cfg_w-1:0] c);
		logic [7:0] b;
		case (idx)
			0:       b = {4'b0011, c[6], c[5], 2'b00};	// function set
			1:       b = {5'b00001, c[4], c[3], c[2]};	// display on/off
			2:       b = 8'h01;							// clear
			default: b = {6'b000001, c[1], c[0]};		// entry mode
		endcase
		return {2'b00, b};
	endfunction

	// bus words for one request, returns how many there are
	function automatic int expected_words(
		input  logic [cfg_w-1:0]     c,
		input  logic [6:0]           cursor,
		input  logic [pos_w-1:0]     pos,
		input  logic [7:0]           ch,
		output logic [lcd_bus_w-1:0] first,
		output logic [lcd_bus_w-1:0] second,
		output logic [6:0]           next_cursor
	);
		logic [7:0] addr;
		int         n;
		addr = {4'h0, pos[3:0]};
		if (pos[4]) begin
			addr = addr + line2_offset;
		end
		second = '0;
		if (addr[6:0] == cursor) begin
			first = {1'b1, 1'b0, ch};		// already in place
			n     = 1;
		end else begin
			first  = {1'b0, 1'b0, cmd_set_ddram | addr};
			second = {1'b1, 1'b0, ch};
			n      = 2;
		end
		next_cursor = c[id_bit] ? addr[6:0] + 7'd1 : addr[6:0] - 7'd1;
		return n;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timed_out = 1'b1;
		other_errors++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic apply_reset(input logic [cfg_w-1:0] new_cfg);
		int n;
		rst        = 1'b1;
		cfg        = new_cfg;
		req_valid  = 1'b0;
		cursor_ref = '0;				// clear homes the cursor
		exp_q.delete();
		repeat (10) next_cycle();
		for (n = 0; n < 4; n++) begin
			exp_q.push_back(init_word(n, new_cfg));
		end
		rst = 1'b0;
		n   = 0;
		if (!timed_out) begin
			while (!init_done && n < init_limit) begin
				next_cycle();
				n++;
			end
			if (!init_done) begin
				note_timeout("init_done after reset");
			end else begin
				check_val("init_done latency", 32'(n), 32'(init_latency));
			end
		end
	endtask

	task automatic send_req(input logic [pos_w-1:0] pos, input logic [7:0] ch, output bit stalled);
		int                   guard;
		int                   n;
		logic [lcd_bus_w-1:0] w0;
		logic [lcd_bus_w-1:0] w1;
		logic [6:0]           nxt;
		stalled = 1'b0;
		guard   = 0;
		if (!timed_out) begin
			req_valid = 1'b1;
			req_pos   = pos;
			req_char  = ch;
			while (!req_ready && guard < ready_limit) begin
				stalled = 1'b1;
				next_cycle();
				guard++;
			end
			if (!req_ready) begin
				note_timeout("req_ready");
			end else begin
				n = expected_words(cfg, cursor_ref, pos, ch, w0, w1, nxt);
				cursor_ref = nxt;
				exp_q.push_back(w0);
				if (n == 2) begin
					exp_q.push_back(w1);
				end
				next_cycle();			// transfer on this edge
			end
			req_valid = 1'b0;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		if (!timed_out) begin
			while (exp_q.size() != 0 && n < drain_limit) begin
				next_cycle();
				n++;
			end
			if (exp_q.size() != 0) begin
				note_timeout("the remaining expected bus words");
			end
		end
	endtask

	task automatic print_report();
		int total;
		total = value_errors + other_errors + bus_errors;
		$display("value errors %0d, other errors %0d, bus timing errors %0d",
			value_errors, other_errors, bus_errors);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
	endtask

	// every captured bus word against the head of the expected queue
	always @(posedge clk) begin
		if (!rst && cap_valid) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("bus word %h appeared when none was expected", cap_word);
			end else begin
				exp_word = exp_q.pop_front();
				check_val("lcd bus word", 32'(cap_word), 32'(exp_word));
			end
		end
	end

	initial begin
		logic [31:0]      r;
		logic [cfg_w-1:0] new_cfg;
		logic [3:0]       col;
		logic             line;
		bit               stalled;
		bit               saw_stall;
		int               i;
		rst          = 1'b1;
		cfg          = '0;
		req_valid    = 1'b0;
		req_pos      = '0;
		req_char     = '0;
		value_errors = 0;
		other_errors = 0;
		timed_out    = 1'b0;
		cursor_ref   = '0;
		next_cycle();

		// increment mode
		r       = next_rand();
		new_cfg = r[6:0] | 7'b0000010;
		apply_reset(new_cfg);

		// line 1 away from the home position, then line 2
		r = next_rand();
		send_req({1'b0, r[19:16] | 4'h1}, r[7:0], stalled);
		wait_drain();
		r = next_rand();
		send_req({1'b1, r[19:16]}, r[7:0], stalled);
		wait_drain();

		// run of increasing columns with random gaps
		r    = next_rand();
		line = r[20];
		col  = {1'b0, r[18:16]};
		for (i = 0; i < 6; i++) begin
			r = next_rand();
			send_req({line, col + 4'(i)}, r[7:0], stalled);
			idle_cycles(int'(r[27:24]));
		end
		wait_drain();

		// back to back burst, deeper than the queue
		saw_stall = 1'b0;
		for (i = 0; i < queue_depth + 4; i++) begin
			r = next_rand();
			send_req(r[20:16], r[7:0], stalled);
			if (stalled) begin
				saw_stall = 1'b1;
			end
		end
		check_val("req_ready low during burst", 32'(saw_stall), 32'd1);
		wait_drain();

		// decrement mode
		r       = next_rand();
		new_cfg = r[6:0] & 7'b1111101;
		apply_reset(new_cfg);
		r    = next_rand();
		line = r[20];
		col  = 4'd4 + {1'b0, r[18:16]};
		send_req({line, col}, r[7:0], stalled);
		r = next_rand();
		send_req({line, col - 4'd1}, r[7:0], stalled);	// cursor already there
		r = next_rand();
		send_req({line, col}, r[7:0], stalled);			// needs a new address
		wait_drain();

		idle_cycles(2 * t_write_us * clk_freq);			// catch any stray bus word
		print_report();
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
design/lcd_pkg.sv
design/char_queue.sv
design/lcd_writer.sv
design/lcd_ctrl.sv
design/lcd_top.sv
tests/lcd_bus_model.sv
tests/lcd_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the LCD testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lcd_tb -f src.f -o lcd_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/lcd_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# pass only when the pass line is in the output
if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
echo "simulation reported failure"
exit 1
